// ==== hw/alu_defines.svh ====
`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// operand and result width
`define ALU_DATA_W 64

// 32-bit forms work on the low half
`define ALU_HALF_W 32

// carry, overflow, adjust, sign, zero, parity
`define ALU_FLAG_W 6

`define ALU_OP_W 5

`define ALU_COND_W 4

`endif

// ==== hw/alu_op_pkg.sv ====
`include "alu_defines.svh"

package alu_op_pkg;

  typedef enum logic [`ALU_OP_W-1:0] {
    add64, add32, sub64, sub32,
    inc64, inc32, dec64, dec32, neg64, neg32,
    and64, and32, or64, or32, xor64, xor32,
    mov64, mov32,
    zxt8, zxt16, sxt8, sxt16, sxt32,
    cmov64, cmov32, cset
  } alu_op_e;

  typedef enum logic {
    width_64,
    width_32
  } op_width_e;

  // extensions and cset produce a full 64-bit result
  function automatic op_width_e op_width(alu_op_e op);
    case (op)
      add32, sub32, inc32, dec32, neg32,
      and32, or32, xor32, mov32, cmov32: return width_32;
      default: return width_64;
    endcase
  endfunction

  function automatic logic op_is_arith(alu_op_e op);
    case (op)
      add64, add32, sub64, sub32,
      inc64, inc32, dec64, dec32, neg64, neg32: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic op_is_logic(alu_op_e op);
    return op inside {and64, and32, or64, or32, xor64, xor32};
  endfunction

endpackage

// ==== hw/alu_flag_pkg.sv ====
`include "alu_defines.svh"

package alu_flag_pkg;

  // bit positions in the COASZP vector
  typedef enum logic [2:0] {
    flag_p = 3'd0,
    flag_z = 3'd1,
    flag_s = 3'd2,
    flag_a = 3'd3,
    flag_o = 3'd4,
    flag_c = 3'd5
  } flag_bit_e;

  typedef enum logic [`ALU_COND_W-1:0] {
    z, nz,
    s, ns,
    ugt, ule,
    uge, ult,
    sgt, sle,
    sge, slt,
    o, no,
    p, np
  } alu_cond_e;

endpackage

// ==== hw/alu_adder.sv ====
`timescale 1ns/1ps
`include "alu_defines.svh"

module alu_adder (
  input  alu_op_pkg::alu_op_e    op,
  input  logic [`ALU_DATA_W-1:0] a,
  input  logic [`ALU_DATA_W-1:0] b,
  output logic [`ALU_DATA_W-1:0] sum,
  output logic                   carry4,
  output logic                   carry32,
  output logic                   carry64
);

  logic [`ALU_DATA_W-1:0] x;
  logic [`ALU_DATA_W-1:0] y;
  logic [`ALU_DATA_W-1:0] y_eff;
  logic                   is_sub;
  logic [`ALU_DATA_W:0]   full;

  // operand pair and direction
  always_comb begin
    x = a;
    y = b;
    is_sub = 1'b0;
    case (op)
      alu_op_pkg::sub64, alu_op_pkg::sub32: is_sub = 1'b1;
      alu_op_pkg::inc64, alu_op_pkg::inc32: y = {{(`ALU_DATA_W-1){1'b0}}, 1'b1};
      alu_op_pkg::dec64, alu_op_pkg::dec32: begin
        y = {{(`ALU_DATA_W-1){1'b0}}, 1'b1};
        is_sub = 1'b1;
      end
      alu_op_pkg::neg64, alu_op_pkg::neg32: begin // 0 - a
        x = '0;
        y = a;
        is_sub = 1'b1;
      end
      default: ;
    endcase
  end

  assign y_eff = is_sub ? ~y : y;
  assign full = {1'b0, x} + {1'b0, y_eff} + {{`ALU_DATA_W{1'b0}}, is_sub};

  assign sum = full[`ALU_DATA_W-1:0];
  assign carry64 = full[`ALU_DATA_W];
  // carry into a bit is the xor of both operand bits and the sum bit
  assign carry32 = x[`ALU_HALF_W] ^ y_eff[`ALU_HALF_W] ^ full[`ALU_HALF_W];
  assign carry4 = x[4] ^ y_eff[4] ^ full[4];

endmodule

// ==== hw/alu_logic_unit.sv ====
`timescale 1ns/1ps
`include "alu_defines.svh"

module alu_logic_unit (
  input  alu_op_pkg::alu_op_e    op,
  input  logic [`ALU_DATA_W-1:0] a,
  input  logic [`ALU_DATA_W-1:0] b,
  input  logic                   take,
  output logic [`ALU_DATA_W-1:0] logic_result
);

  logic [`ALU_DATA_W-1:0] full;

  always_comb begin
    case (op)
      alu_op_pkg::and64, alu_op_pkg::and32: full = a & b;
      alu_op_pkg::or64, alu_op_pkg::or32:   full = a | b;
      alu_op_pkg::xor64, alu_op_pkg::xor32: full = a ^ b;
      alu_op_pkg::mov64, alu_op_pkg::mov32: full = b;
      alu_op_pkg::zxt8: begin
        full = {{(`ALU_DATA_W-8){1'b0}}, b[7:0]};
      end
      alu_op_pkg::zxt16: begin
        full = {{(`ALU_DATA_W-16){1'b0}}, b[15:0]};
      end
      alu_op_pkg::sxt8: begin
        full = {{(`ALU_DATA_W-8){b[7]}}, b[7:0]};
      end
      alu_op_pkg::sxt16: begin
        full = {{(`ALU_DATA_W-16){b[15]}}, b[15:0]};
      end
      alu_op_pkg::sxt32: begin
        full = {{(`ALU_DATA_W-`ALU_HALF_W){b[`ALU_HALF_W-1]}}, b[`ALU_HALF_W-1:0]};
      end
      alu_op_pkg::cmov64, alu_op_pkg::cmov32: full = take ? b : a;
      alu_op_pkg::cset: full = {{(`ALU_DATA_W-1){1'b0}}, take};
      default: full = '0; // arithmetic uses the adder result
    endcase
  end

  always_comb begin
    logic_result = full;
    if (alu_op_pkg::op_width(op) == alu_op_pkg::width_32) begin
      logic_result[`ALU_DATA_W-1:`ALU_HALF_W] = '0;
    end
  end

endmodule

// ==== hw/alu_cond_eval.sv ====
`timescale 1ns/1ps
`include "alu_defines.svh"

module alu_cond_eval (
  input  alu_flag_pkg::alu_cond_e cond,
  input  logic [`ALU_FLAG_W-1:0]  flags,
  output logic                    take
);

  logic c;
  logic o;
  logic s;
  logic z;
  logic p;
  logic lt; // signed less than

  assign c = flags[alu_flag_pkg::flag_c];
  assign o = flags[alu_flag_pkg::flag_o];
  assign s = flags[alu_flag_pkg::flag_s];
  assign z = flags[alu_flag_pkg::flag_z];
  assign p = flags[alu_flag_pkg::flag_p];
  assign lt = s ^ o;

  always_comb begin
    case (cond)
      alu_flag_pkg::z:   take = z;
      alu_flag_pkg::nz:  take = ~z;
      alu_flag_pkg::s:   take = s;
      alu_flag_pkg::ns:  take = ~s;
      alu_flag_pkg::ugt: take = ~(c | z);
      alu_flag_pkg::ule: take = c | z;
      alu_flag_pkg::uge: take = ~c;
      alu_flag_pkg::ult: take = c;
      alu_flag_pkg::sgt: take = ~(lt | z);
      alu_flag_pkg::sle: take = lt | z;
      alu_flag_pkg::sge: take = ~lt;
      alu_flag_pkg::slt: take = lt;
      alu_flag_pkg::o:   take = o;
      alu_flag_pkg::no:  take = ~o;
      alu_flag_pkg::p:   take = p;
      alu_flag_pkg::np:  take = ~p;
      default:           take = 1'b0;
    endcase
  end

endmodule

// ==== hw/alu_output_stage.sv ====
`timescale 1ns/1ps
`include "alu_defines.svh"

module alu_output_stage (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   in_valid,
  output logic                   in_ready,
  input  alu_op_pkg::alu_op_e    op,
  input  logic                   set_flags,
  input  logic [`ALU_FLAG_W-1:0] flags_in,
  input  logic                   thread,
  input  logic [`ALU_DATA_W-1:0] a,
  input  logic [`ALU_DATA_W-1:0] b,
  input  logic [`ALU_DATA_W-1:0] sum,
  input  logic                   carry4,
  input  logic                   carry32,
  input  logic                   carry64,
  input  logic [`ALU_DATA_W-1:0] logic_result,
  input  logic                   except,
  input  logic                   except_thread,
  output logic                   out_valid,
  input  logic                   out_ready,
  output logic [`ALU_DATA_W-1:0] result,
  output logic                   flags_wr,
  output logic [`ALU_FLAG_W-1:0] flags_out,
  output logic                   out_thread
);

  logic                   valid_q;
  logic                   accept;
  logic                   kill_held;
  logic                   kill_new;
  logic                   in_w32;
  logic                   sign_a;
  logic                   sign_b;
  logic                   sign_x; // adder operand signs
  logic                   sign_y;
  logic [`ALU_DATA_W-1:0] res_sel;

  logic [`ALU_DATA_W-1:0] res_q;
  logic                   c4_q;
  logic                   c32_q;
  logic                   c64_q;
  logic                   sx_q;
  logic                   sy_q;
  logic                   a_nz_q;
  alu_op_pkg::alu_op_e    op_q;
  logic                   set_flags_q;
  logic [`ALU_FLAG_W-1:0] flags_in_q;
  logic                   thread_q;

  logic                   w32;
  logic                   sr;
  logic                   cy;
  logic                   ov_add;
  logic                   ov_sub;

  assign in_ready = ~valid_q | out_ready;
  assign accept = in_valid & in_ready;
  assign kill_held = except & valid_q & (thread_q == except_thread);
  assign kill_new = except & (thread == except_thread);

  assign in_w32 = alu_op_pkg::op_width(op) == alu_op_pkg::width_32;
  assign sign_a = in_w32 ? a[`ALU_HALF_W-1] : a[`ALU_DATA_W-1];
  assign sign_b = in_w32 ? b[`ALU_HALF_W-1] : b[`ALU_DATA_W-1];

  always_comb begin
    sign_x = sign_a;
    sign_y = sign_b;
    case (op)
      alu_op_pkg::inc64, alu_op_pkg::inc32,
      alu_op_pkg::dec64, alu_op_pkg::dec32: sign_y = 1'b0; // constant one
      alu_op_pkg::neg64, alu_op_pkg::neg32: begin
        sign_x = 1'b0;
        sign_y = sign_a;
      end
      default: ;
    endcase
  end

  always_comb begin
    res_sel = alu_op_pkg::op_is_arith(op) ? sum : logic_result;
    if (alu_op_pkg::op_is_arith(op) && in_w32) begin
      res_sel[`ALU_DATA_W-1:`ALU_HALF_W] = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= ~kill_new; // old item left or was empty
    end else if (out_ready || kill_held) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      res_q       <= res_sel;
      c4_q        <= carry4;
      c32_q       <= carry32;
      c64_q       <= carry64;
      sx_q        <= sign_x;
      sy_q        <= sign_y;
      a_nz_q      <= in_w32 ? |a[`ALU_HALF_W-1:0] : |a;
      op_q        <= op;
      set_flags_q <= set_flags;
      flags_in_q  <= flags_in;
      thread_q    <= thread;
    end
  end

  // flags from registered values
  assign w32 = alu_op_pkg::op_width(op_q) == alu_op_pkg::width_32;
  assign sr = w32 ? res_q[`ALU_HALF_W-1] : res_q[`ALU_DATA_W-1];
  assign cy = w32 ? c32_q : c64_q;
  assign ov_add = (sx_q & sy_q & ~sr) | (~sx_q & ~sy_q & sr);
  assign ov_sub = (sx_q & ~sy_q & ~sr) | (~sx_q & sy_q & sr);

  always_comb begin
    flags_out = flags_in_q;
    if (alu_op_pkg::op_is_arith(op_q) || alu_op_pkg::op_is_logic(op_q)) begin
      flags_out[alu_flag_pkg::flag_s] = sr;
      flags_out[alu_flag_pkg::flag_z] = ~|res_q;
      flags_out[alu_flag_pkg::flag_p] = ~^res_q[7:0];
    end
    case (op_q)
      alu_op_pkg::add64, alu_op_pkg::add32: begin
        flags_out[alu_flag_pkg::flag_c] = cy;
        flags_out[alu_flag_pkg::flag_o] = ov_add;
        flags_out[alu_flag_pkg::flag_a] = c4_q;
      end
      alu_op_pkg::sub64, alu_op_pkg::sub32: begin // borrows
        flags_out[alu_flag_pkg::flag_c] = ~cy;
        flags_out[alu_flag_pkg::flag_o] = ov_sub;
        flags_out[alu_flag_pkg::flag_a] = ~c4_q;
      end
      alu_op_pkg::inc64, alu_op_pkg::inc32: begin
        flags_out[alu_flag_pkg::flag_o] = ov_add;
        flags_out[alu_flag_pkg::flag_a] = c4_q;
      end
      alu_op_pkg::dec64, alu_op_pkg::dec32: begin
        flags_out[alu_flag_pkg::flag_o] = ov_sub;
        flags_out[alu_flag_pkg::flag_a] = ~c4_q;
      end
      alu_op_pkg::neg64, alu_op_pkg::neg32: begin
        flags_out[alu_flag_pkg::flag_c] = a_nz_q;
        flags_out[alu_flag_pkg::flag_o] = ov_sub;
        flags_out[alu_flag_pkg::flag_a] = ~c4_q;
      end
      alu_op_pkg::and64, alu_op_pkg::and32,
      alu_op_pkg::or64, alu_op_pkg::or32,
      alu_op_pkg::xor64, alu_op_pkg::xor32: begin
        flags_out[alu_flag_pkg::flag_c] = 1'b0;
        flags_out[alu_flag_pkg::flag_o] = 1'b0;
        flags_out[alu_flag_pkg::flag_a] = 1'b0;
      end
      default: ;
    endcase
  end

  // a killed item drops off the output in the same cycle
  assign out_valid = valid_q & ~kill_held;
  assign result = res_q;
  assign out_thread = thread_q;
  assign flags_wr = out_valid & set_flags_q &
                    (alu_op_pkg::op_is_arith(op_q) | alu_op_pkg::op_is_logic(op_q));

endmodule

// ==== hw/alu_core.sv ====
`timescale 1ns/1ps
`include "alu_defines.svh"

module alu_core (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    in_valid,
  output logic                    in_ready,
  input  alu_op_pkg::alu_op_e     op,
  input  alu_flag_pkg::alu_cond_e cond,
  input  logic                    set_flags,
  input  logic [`ALU_FLAG_W-1:0]  flags_in,
  input  logic                    thread,
  input  logic [`ALU_DATA_W-1:0]  a,
  input  logic [`ALU_DATA_W-1:0]  b,
  input  logic                    except,
  input  logic                    except_thread,
  output logic                    out_valid,
  input  logic                    out_ready,
  output logic [`ALU_DATA_W-1:0]  result,
  output logic                    flags_wr,
  output logic [`ALU_FLAG_W-1:0]  flags_out,
  output logic                    out_thread
);

  logic [`ALU_DATA_W-1:0] sum;
  logic                   carry4;
  logic                   carry32;
  logic                   carry64;
  logic                   take;
  logic [`ALU_DATA_W-1:0] logic_result;

  alu_adder u_adder (
    .op      (op),
    .a       (a),
    .b       (b),
    .sum     (sum),
    .carry4  (carry4),
    .carry32 (carry32),
    .carry64 (carry64)
  );

  // condition checked against the incoming flags
  alu_cond_eval u_cond_eval (
    .cond  (cond),
    .flags (flags_in),
    .take  (take)
  );

  alu_logic_unit u_logic_unit (
    .op           (op),
    .a            (a),
    .b            (b),
    .take         (take),
    .logic_result (logic_result)
  );

  alu_output_stage u_output_stage (
    .clk           (clk),
    .rst           (rst),
    .in_valid      (in_valid),
    .in_ready      (in_ready),
    .op            (op),
    .set_flags     (set_flags),
    .flags_in      (flags_in),
    .thread        (thread),
    .a             (a),
    .b             (b),
    .sum           (sum),
    .carry4        (carry4),
    .carry32       (carry32),
    .carry64       (carry64),
    .logic_result  (logic_result),
    .except        (except),
    .except_thread (except_thread),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .result        (result),
    .flags_wr      (flags_wr),
    .flags_out     (flags_out),
    .out_thread    (out_thread)
  );

endmodule

// ==== verif/alu_assertions.sv ====
`timescale 1ns/1ps
`include "alu_defines.svh"

module alu_assertions (
  input logic                   clk,
  input logic                   rst,
  input logic                   valid_q,
  input logic                   except,
  input logic                   in_ready,
  input logic                   out_valid,
  input logic                   out_ready,
  input logic                   flags_wr,
  input logic [`ALU_DATA_W-1:0] result,
  input logic [`ALU_FLAG_W-1:0] flags_out,
  input logic                   out_thread
);

  // register empty right after reset
  a_reset_empty: assert property (@(posedge clk) rst |=> !out_valid && !flags_wr)
    else $error("output valid after reset");

  // a stalled item holds while no exception is raised
  a_stall_hold: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready && !except |=>
      valid_q && $stable(result) && $stable(flags_out) && $stable(out_thread))
    else $error("output changed while stalled");

  a_full_not_ready: assert property (@(posedge clk) disable iff (rst)
    valid_q && !out_ready |-> !in_ready)
    else $error("in_ready high with full register and no out_ready");

endmodule

bind alu_output_stage alu_assertions u_assertions (
  .clk        (clk),
  .rst        (rst),
  .valid_q    (valid_q),
  .except     (except),
  .in_ready   (in_ready),
  .out_valid  (out_valid),
  .out_ready  (out_ready),
  .flags_wr   (flags_wr),
  .result     (result),
  .flags_out  (flags_out),
  .out_thread (out_thread)
);

// ==== verif/alu_tb.sv ====
`timescale 1ns/1ps
`include "alu_defines.svh"

module alu_tb;

  localparam int COLS = 11;
  localparam int MAX_VEC = 128;
  localparam int TIMEOUT = 500;

  logic clk;
  logic rst;
  logic in_valid;
  logic in_ready;
  alu_op_pkg::alu_op_e op;
  alu_flag_pkg::alu_cond_e cond;
  logic set_flags;
  logic [`ALU_FLAG_W-1:0] flags_in;
  logic thread;
  logic [`ALU_DATA_W-1:0] a;
  logic [`ALU_DATA_W-1:0] b;
  logic except;
  logic except_thread;
  logic out_valid;
  logic out_ready;
  logic [`ALU_DATA_W-1:0] result;
  logic flags_wr;
  logic [`ALU_FLAG_W-1:0] flags_out;
  logic out_thread;

  logic [63:0] vec_mem [0:COLS*MAX_VEC-1];
  int n_vec;
  int errors;
  int sent_live;
  int rcv_cnt;
  int killed_cnt;
  int exp_q[$];
  int seed;

  alu_core u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // random back-pressure with 3 of 4 cycles ready
  always @(posedge clk) begin
    #1;
    out_ready = ($random(seed) & 3) != 0;
  end

  task automatic stop_on_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("Simulation failed");
    $finish;
  endtask

  task automatic check_output();
    int idx;
    int base;
    logic bad;
    bad = 1'b0;
    if (exp_q.size() == 0) begin
      errors++;
      $display("item presented with no item pending, result %h", result);
    end else begin
      idx = exp_q.pop_front();
      base = idx * COLS;
      if (result !== vec_mem[base+8]) begin
        $display("[FAIL] test %0d result: expected %h, got %h", idx, vec_mem[base+8], result);
        bad = 1'b1;
      end
      if (flags_wr !== vec_mem[base+9][0]) begin
        $display("[FAIL] test %0d flags_wr: expected %h, got %h", idx,
                 vec_mem[base+9][0], flags_wr);
        bad = 1'b1;
      end
      if (flags_out !== vec_mem[base+10][`ALU_FLAG_W-1:0]) begin
        $display("[FAIL] test %0d flags_out: expected %h, got %h", idx,
                 vec_mem[base+10][`ALU_FLAG_W-1:0], flags_out);
        bad = 1'b1;
      end
      if (out_thread !== vec_mem[base+5][0]) begin
        $display("[FAIL] test %0d out_thread: expected %h, got %h", idx,
                 vec_mem[base+5][0], out_thread);
        bad = 1'b1;
      end
      if (bad) begin
        errors++;
      end else begin
        $display("test %0d passed", idx);
      end
    end
    rcv_cnt++;
  endtask

  // compare at the falling edge once the handshake has settled
  always @(negedge clk) begin
    if (!rst && out_valid && out_ready) begin
      check_output();
    end
  end

  task automatic wait_drained();
    int t;
    t = 0;
    in_valid = 1'b0;
    except = 1'b0;
    while (rcv_cnt < sent_live) begin
      @(posedge clk);
      #1;
      t++;
      if (t > TIMEOUT) stop_on_timeout("outstanding items to drain");
    end
  endtask

  task automatic drive_item(input int base, input logic kill);
    int t;
    op = alu_op_pkg::alu_op_e'(vec_mem[base+1][`ALU_OP_W-1:0]);
    cond = alu_flag_pkg::alu_cond_e'(vec_mem[base+2][`ALU_COND_W-1:0]);
    set_flags = vec_mem[base+3][0];
    flags_in = vec_mem[base+4][`ALU_FLAG_W-1:0];
    thread = vec_mem[base+5][0];
    a = vec_mem[base+6];
    b = vec_mem[base+7];
    if (kill) begin
      except = 1'b1;
      except_thread = thread;
    end else if (thread == except_thread) begin
      except = 1'b0;
    end
    in_valid = 1'b1;
    t = 0;
    do begin
      @(negedge clk);
      t++;
      if (t > TIMEOUT) stop_on_timeout("in_ready");
    end while (!in_ready);
    @(posedge clk);
    #1;
  endtask

  task automatic send_item(input int i);
    int base;
    base = i * COLS;
    if (vec_mem[base][0]) begin
      // first copy waits in the register and the second arrives with the kill
      wait_drained();
      drive_item(base, 1'b0);
      drive_item(base, 1'b1);
      killed_cnt++;
      $display("test %0d killed on thread %0d", i, thread);
    end else begin
      drive_item(base, 1'b0);
      except = 1'b0; // kill ends once the other thread's item is in
      exp_q.push_back(i);
      sent_live++;
    end
  endtask

  initial begin
    rst = 1'b1;
    in_valid = 1'b0;
    op = alu_op_pkg::add64;
    cond = alu_flag_pkg::z;
    set_flags = 1'b0;
    flags_in = '0;
    thread = 1'b0;
    a = '0;
    b = '0;
    except = 1'b0;
    except_thread = 1'b0;
    out_ready = 1'b0;
    errors = 0;
    sent_live = 0;
    rcv_cnt = 0;
    killed_cnt = 0;
    seed = 32'hbf2f;

    for (int i = 0; i < COLS * MAX_VEC; i++) begin
      vec_mem[i] = {32'hffff_ffff, 32'(i)}; // kill column > 1 marks the end
    end
    $readmemh("verif/alu_input.txt", vec_mem);
    n_vec = 0;
    while (n_vec < MAX_VEC && vec_mem[n_vec*COLS] <= 64'd1) n_vec++;

    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;

    for (int i = 0; i < n_vec; i++) begin
      send_item(i);
    end
    wait_drained();
    repeat (4) @(posedge clk);

    $display("checked %0d, killed %0d, errors %0d", rcv_cnt, killed_cnt, errors);
    if (errors == 0 && rcv_cnt == sent_live && n_vec > 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== alu_core.f ====
+incdir+hw
hw/alu_op_pkg.sv
hw/alu_flag_pkg.sv
hw/alu_adder.sv
hw/alu_logic_unit.sv
hw/alu_cond_eval.sv
hw/alu_output_stage.sv
hw/alu_core.sv
verif/alu_assertions.sv
verif/alu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the ALU testbench with Verilator

verilator --binary --timing --assert -Wall -Wno-fatal --top-module alu_tb \
  -f alu_core.f -o alu_sim > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/alu_sim > sim.log 2>&1
cat sim.log

grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation completed successfully" sim.log || exit 1
exit 0

// ==== verif/alu_input.txt ====
// kill op cond set_flags flags_in thread a b | expected result flags_wr flags_out
// all hex, one operation per line
0 00 0 1 00 0 0000000000000001 0000000000000002 0000000000000003 1 01
0 00 0 1 00 1 ffffffffffffffff 0000000000000001 0000000000000000 1 2b
0 00 0 1 00 0 7fffffffffffffff 0000000000000001 8000000000000000 1 1d
0 01 0 1 00 1 12345678ffffffff 0000000000000001 0000000000000000 1 2b
0 01 0 1 00 0 000000007fffffff 0000000000000001 0000000080000000 1 1d
0 02 0 1 00 0 0000000000000000 0000000000000001 ffffffffffffffff 1 2d
0 02 0 1 00 1 8000000000000000 0000000000000001 7fffffffffffffff 1 19
0 03 0 1 00 0 0000000000000010 0000000000000020 00000000fffffff0 1 25
0 03 0 0 00 1 0000000080000000 0000000000000001 000000007fffffff 0 19
0 04 0 1 20 0 000000000000000f 0000000000000000 0000000000000010 1 28
0 05 0 1 00 1 00000000ffffffff 0000000000000000 0000000000000000 1 0b
0 07 0 1 20 0 0000000080000000 0000000000000000 000000007fffffff 1 39
0 06 0 1 20 1 0000000000000001 0000000000000000 0000000000000000 1 23
0 08 0 1 00 0 0000000000000001 0000000000000000 ffffffffffffffff 1 2d
0 08 0 1 00 1 0000000000000000 0000000000000000 0000000000000000 1 03
0 09 0 1 00 0 0000000080000000 0000000000000000 0000000080000000 1 35
0 09 0 1 00 1 ffffffff00000010 0000000000000000 00000000fffffff0 1 25
1 00 0 1 00 1 0000000000000005 0000000000000005 0000000000000000 0 00
0 00 0 1 00 0 0000000000000005 0000000000000005 000000000000000a 1 01
0 0a 0 1 38 0 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 0f000f000f000f00 1 01
0 0d 0 1 3f 1 ffffffff00000000 1234567880000001 0000000080000001 1 04
0 0e 0 1 38 0 aaaaaaaaaaaaaaaa aaaaaaaaaaaaaaaa 0000000000000000 1 03
0 0f 0 1 00 1 0000000000000000 ffffffffffffff03 00000000ffffff03 1 05
0 0b 0 0 00 0 000000000000ffff 00000000000000ff 00000000000000ff 0 01
0 10 0 1 15 0 1111111111111111 123456789abcdef0 123456789abcdef0 0 15
0 11 0 1 2a 1 1111111111111111 fedcba9876543210 0000000076543210 0 2a
0 12 0 1 00 0 0000000000000000 ffffffffffffff80 0000000000000080 0 00
0 13 0 1 07 1 0000000000000000 123456789abc8001 0000000000008001 0 07
0 14 0 1 00 0 0000000000000000 0000000000000080 ffffffffffffff80 0 00
0 14 0 1 00 1 0000000000000000 ffffffffffffff7f 000000000000007f 0 00
0 15 0 1 00 0 0000000000000000 0000000000008000 ffffffffffff8000 0 00
0 16 0 1 00 1 0000000000000000 0000000080000000 ffffffff80000000 0 00
0 16 0 1 00 0 0000000000000000 ffffffff7fffffff 000000007fffffff 0 00
1 02 0 1 00 0 0000000000000009 0000000000000004 0000000000000000 0 00
0 02 0 1 00 1 0000000000000009 0000000000000004 0000000000000005 1 01
0 17 0 1 02 0 1111111111111111 2222222222222222 2222222222222222 0 02
0 17 0 1 00 1 1111111111111111 2222222222222222 1111111111111111 0 00
0 18 1 0 00 0 aaaaaaaa11111111 bbbbbbbb22222222 0000000022222222 0 00
0 18 1 0 02 1 aaaaaaaa11111111 bbbbbbbb22222222 0000000011111111 0 02
0 19 2 1 04 0 0000000000000000 0000000000000000 0000000000000001 0 04
0 19 2 1 00 1 0000000000000000 0000000000000000 0000000000000000 0 00
0 19 3 0 00 0 0000000000000000 0000000000000000 0000000000000001 0 00
0 19 3 0 04 1 0000000000000000 0000000000000000 0000000000000000 0 04
0 17 4 1 00 0 1111111111111111 2222222222222222 2222222222222222 0 00
0 17 4 1 20 1 1111111111111111 2222222222222222 1111111111111111 0 20
0 19 5 1 02 0 0000000000000000 0000000000000000 0000000000000001 0 02
0 19 5 1 00 1 0000000000000000 0000000000000000 0000000000000000 0 00
0 19 6 0 00 0 0000000000000000 0000000000000000 0000000000000001 0 00
0 19 6 0 20 1 0000000000000000 0000000000000000 0000000000000000 0 20
0 19 7 1 20 0 0000000000000000 0000000000000000 0000000000000001 0 20
0 19 7 1 00 1 0000000000000000 0000000000000000 0000000000000000 0 00
0 17 8 1 00 0 1111111111111111 2222222222222222 2222222222222222 0 00
0 17 8 1 04 1 1111111111111111 2222222222222222 1111111111111111 0 04
0 19 9 0 10 0 0000000000000000 0000000000000000 0000000000000001 0 10
0 19 9 0 14 1 0000000000000000 0000000000000000 0000000000000000 0 14
0 19 a 1 14 0 0000000000000000 0000000000000000 0000000000000001 0 14
0 19 a 1 04 1 0000000000000000 0000000000000000 0000000000000000 0 04
0 19 b 1 04 0 0000000000000000 0000000000000000 0000000000000001 0 04
0 19 b 1 14 1 0000000000000000 0000000000000000 0000000000000000 0 14
0 18 c 1 10 0 aaaaaaaa11111111 bbbbbbbb22222222 0000000022222222 0 10
0 18 c 1 00 1 aaaaaaaa11111111 bbbbbbbb22222222 0000000011111111 0 00
0 19 d 0 00 0 0000000000000000 0000000000000000 0000000000000001 0 00
0 19 d 0 10 1 0000000000000000 0000000000000000 0000000000000000 0 10
0 17 e 1 01 0 1111111111111111 2222222222222222 2222222222222222 0 01
0 17 e 1 00 1 1111111111111111 2222222222222222 1111111111111111 0 00
0 19 f 1 00 0 0000000000000000 0000000000000000 0000000000000001 0 00
0 19 f 1 01 1 0000000000000000 0000000000000000 0000000000000000 0 01
